// File: Bender.yml
package:
  name: maze_top

sources:
  - hw/maze_pkg.sv
  - hw/grid_port_if.sv
  - hw/game_sequencer.sv
  - hw/grid_store.sv
  - hw/level_loader.sv
  - hw/map_renderer.sv
  - hw/player_motion.sv
  - hw/hex_readout.sv
  - hw/maze_top.sv
  - target: simulation
    files:
      - testbench/clock_gen.sv
      - testbench/maze_assert.sv
      - testbench/tb_maze_top.sv

// File: all.f
hw/maze_pkg.sv
hw/grid_port_if.sv
hw/game_sequencer.sv
hw/grid_store.sv
hw/level_loader.sv
hw/map_renderer.sv
hw/player_motion.sv
hw/hex_readout.sv
hw/maze_top.sv
testbench/clock_gen.sv
testbench/maze_assert.sv
testbench/tb_maze_top.sv

// File: hw/game_sequencer.sv
`timescale 1ns/1ps

module game_sequencer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load_done,
    input  logic                  draw_done,
    input  logic                  update_done,
    output logic                  load_start,
    output logic                  draw_start,
    output logic                  update_start,
    output logic                  store,
    output maze_pkg::grid_owner_t owner
);
    import maze_pkg::*;

    typedef enum logic [2:0] {
        LOAD,
        WAIT_LOAD,
        DRAW,
        WAIT_DRAW,
        UPDATE,
        WAIT_UPDATE,
        STORE
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            LOAD:        state_next = WAIT_LOAD;
            WAIT_LOAD:   state_next = load_done ? DRAW : WAIT_LOAD;
            DRAW:        state_next = WAIT_DRAW;
            WAIT_DRAW:   state_next = draw_done ? UPDATE : WAIT_DRAW;
            UPDATE:      state_next = WAIT_UPDATE;
            WAIT_UPDATE: state_next = update_done ? STORE : WAIT_UPDATE;
            STORE:       state_next = DRAW;
            default:     state_next = LOAD;
        endcase
    end

    // Pulses land in the first WAIT cycle, so each worker starts under its own owner
    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= LOAD;
            load_start   <= 1'b0;
            draw_start   <= 1'b0;
            update_start <= 1'b0;
            store        <= 1'b0;
        end else begin
            state        <= state_next;
            load_start   <= (state == LOAD);
            draw_start   <= (state == DRAW);
            update_start <= (state == UPDATE);
            store        <= (state == STORE);
        end
    end

    always_comb begin
        case (state)
            WAIT_LOAD:   owner = OWNER_LOAD;
            WAIT_DRAW:   owner = OWNER_DRAW;
            WAIT_UPDATE: owner = OWNER_MOTION;
            default:     owner = OWNER_NONE;
        endcase
    end

endmodule

// File: hw/grid_port_if.sv
`timescale 1ns/1ps

interface grid_port_if;
    import maze_pkg::*;

    logic [GRID_X_BITS-1:0] x;
    logic [GRID_Y_BITS-1:0] y;
    logic                   write;
    cell_t                  wdata;
    // Valid one cycle after the address
    cell_t                  rdata;

    modport client (
        output x, y, write, wdata,
        input  rdata
    );

    modport store (
        input  x, y, write, wdata,
        output rdata
    );

endinterface

// File: hw/grid_store.sv
`timescale 1ns/1ps

module grid_store (
    input  logic                  clock,
    input  maze_pkg::grid_owner_t owner,
    grid_port_if.store            load_port,
    grid_port_if.store            draw_port,
    grid_port_if.store            motion_port
);
    import maze_pkg::*;

    cell_t                     mem [GRID_CELLS];
    logic [GRID_ADDR_BITS-1:0] addr;
    logic                      write;
    cell_t                     wdata;
    cell_t                     rdata_q;
    grid_owner_t               owner_q;

    // Only the owning port reaches the memory
    always_comb begin
        addr  = '0;
        write = 1'b0;
        wdata = CELL_FLOOR;
        case (owner)
            OWNER_LOAD: begin
                addr  = {load_port.y, load_port.x};
                write = load_port.write;
                wdata = load_port.wdata;
            end
            OWNER_DRAW: begin
                addr  = {draw_port.y, draw_port.x};
                write = draw_port.write;
                wdata = draw_port.wdata;
            end
            OWNER_MOTION: begin
                addr  = {motion_port.y, motion_port.x};
                write = motion_port.write;
                wdata = motion_port.wdata;
            end
            default: write = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (write)
            mem[addr] <= wdata;
        rdata_q <= mem[addr];
        owner_q <= owner;
    end

    // Read data goes back to whoever owned the address cycle
    assign load_port.rdata   = (owner_q == OWNER_LOAD)   ? rdata_q : CELL_FLOOR;
    assign draw_port.rdata   = (owner_q == OWNER_DRAW)   ? rdata_q : CELL_FLOOR;
    assign motion_port.rdata = (owner_q == OWNER_MOTION) ? rdata_q : CELL_FLOOR;

endmodule

// File: hw/hex_readout.sv
`timescale 1ns/1ps

module hex_readout (
    input  maze_pkg::pos_x_t    pos_x,
    input  maze_pkg::pos_y_t    pos_y,
    input  maze_pkg::angle_t    angle,
    output maze_pkg::segments_t hex0,
    output maze_pkg::segments_t hex1,
    output maze_pkg::segments_t hex4,
    output maze_pkg::segments_t hex5,
    output maze_pkg::segments_t hex6,
    output maze_pkg::segments_t hex7
);
    import maze_pkg::*;

    // Cell index and top nibble of the fraction
    assign hex7 = HEX_SEGMENTS[pos_x[11:8]];
    assign hex6 = HEX_SEGMENTS[pos_x[7:4]];

    assign hex5 = HEX_SEGMENTS[pos_y[11:8]];
    assign hex4 = HEX_SEGMENTS[pos_y[7:4]];

    assign hex1 = HEX_SEGMENTS[angle[7:4]];
    assign hex0 = HEX_SEGMENTS[angle[3:0]];

endmodule

// File: hw/level_loader.sv
`timescale 1ns/1ps

module level_loader (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    output logic        done,
    grid_port_if.client grid
);
    import maze_pkg::*;

    logic [GRID_ADDR_BITS-1:0] idx;
    logic                      busy;
    logic                      writing;

    // Border ring plus a regular lattice of pillars
    function automatic cell_t level_cell(input logic [GRID_X_BITS-1:0] x,
                                         input logic [GRID_Y_BITS-1:0] y);
        logic border;
        logic pillar;
        border = (x == '0) || (x == '1) || (y == '0) || (y == '1);
        pillar = ((x % PILLAR_SPACING) == PILLAR_OFFSET) &&
                 ((y % PILLAR_SPACING) == PILLAR_OFFSET);
        return (border || pillar) ? CELL_WALL : CELL_FLOOR;
    endfunction

    // Cell 0 goes out on the start cycle itself
    assign writing    = start || busy;
    assign grid.x     = idx[GRID_X_BITS-1:0];
    assign grid.y     = idx[GRID_X_BITS +: GRID_Y_BITS];
    assign grid.write = writing;
    assign grid.wdata = level_cell(grid.x, grid.y);

    always_ff @(posedge clock) begin
        if (reset) begin
            idx  <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= writing && (idx == '1);
            if (writing)
                idx <= idx + 1'b1;
            if (start)
                busy <= 1'b1;
            else if (idx == '1)
                busy <= 1'b0;
        end
    end

endmodule

// File: hw/map_renderer.sv
`timescale 1ns/1ps

module map_renderer (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               start,
    output logic                               done,
    grid_port_if.client                        grid,
    output logic [maze_pkg::VGA_X_BITS-1:0]    vga_x,
    output logic [maze_pkg::VGA_Y_BITS-1:0]    vga_y,
    output maze_pkg::colour_t                  vga_colour,
    output logic                               vga_write
);
    import maze_pkg::*;

    logic [LIMIT_BITS-1:0]     limiter;
    logic                      window_open;
    logic [GRID_ADDR_BITS-1:0] idx;
    logic                      busy;
    logic                      advance;
    logic                      pixel_last;

    // Free-running frame limiter
    always_ff @(posedge clock) begin
        if (reset || limiter == '0)
            limiter <= FRAME_PERIOD;
        else
            limiter <= limiter - 1'b1;
    end

    assign window_open = (limiter < DRAW_WINDOW);
    assign advance     = busy && window_open;

    assign grid.x     = idx[GRID_X_BITS-1:0];
    assign grid.y     = idx[GRID_X_BITS +: GRID_Y_BITS];
    assign grid.write = 1'b0;
    assign grid.wdata = CELL_FLOOR;

    // Cell type arrives with the pixel write
    assign vga_colour = (grid.rdata == CELL_WALL) ? WALL_COLOUR : FLOOR_COLOUR;

    always_ff @(posedge clock) begin
        if (reset) begin
            idx        <= '0;
            busy       <= 1'b0;
            vga_write  <= 1'b0;
            pixel_last <= 1'b0;
            done       <= 1'b0;
        end else begin
            vga_write  <= advance;
            pixel_last <= advance && (idx == '1);
            done       <= pixel_last;
            if (advance)
                idx <= idx + 1'b1;
            if (start)
                busy <= 1'b1;
            else if (advance && idx == '1)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        vga_x <= VGA_X_BITS'(grid.x);
        vga_y <= VGA_Y_BITS'(grid.y);
    end

endmodule

// File: hw/maze_pkg.sv
package maze_pkg;

    // Grid geometry, 64 by 32 cells
    localparam int GRID_X_BITS    = 6;
    localparam int GRID_Y_BITS    = 5;
    localparam int GRID_ADDR_BITS = GRID_X_BITS + GRID_Y_BITS;
    localparam int GRID_CELLS     = 1 << GRID_ADDR_BITS;

    // Fixed point player coordinates
    localparam int FRAC_BITS = 8;

    localparam int VGA_X_BITS = 8;
    localparam int VGA_Y_BITS = 7;
    localparam int LIMIT_BITS = 13;

    typedef logic [GRID_X_BITS+FRAC_BITS-1:0] pos_x_t;
    typedef logic [GRID_Y_BITS+FRAC_BITS-1:0] pos_y_t;
    typedef logic [7:0]  angle_t;
    typedef logic [17:0] colour_t;
    typedef logic [6:0]  segments_t;

    typedef enum logic [2:0] {
        CELL_FLOOR = 3'd0,
        CELL_WALL  = 3'd1
    } cell_t;

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_LOAD,
        OWNER_DRAW,
        OWNER_MOTION
    } grid_owner_t;

    // Cell (1,1), half a cell in
    localparam pos_x_t START_X = pos_x_t'(384);
    localparam pos_y_t START_Y = pos_y_t'(384);

    localparam int unsigned MOVE_STEP = 32;
    localparam angle_t      ANGLE_STEP = 8'd4;

    localparam logic [LIMIT_BITS-1:0] FRAME_PERIOD = 13'd4096;
    localparam logic [LIMIT_BITS-1:0] DRAW_WINDOW  = 13'd2560;

    localparam colour_t WALL_COLOUR  = 18'h3FFFF;
    localparam colour_t FLOOR_COLOUR = 18'h0003F;

    localparam int unsigned PILLAR_SPACING = 8;
    localparam int unsigned PILLAR_OFFSET  = 4;

    // Active low, bit 0 is segment a
    localparam segments_t HEX_SEGMENTS [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

// File: hw/maze_top.sv
`timescale 1ns/1ps

module maze_top (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [17:0]                     sw,
    output maze_pkg::segments_t             hex0,
    output maze_pkg::segments_t             hex1,
    output maze_pkg::segments_t             hex4,
    output maze_pkg::segments_t             hex5,
    output maze_pkg::segments_t             hex6,
    output maze_pkg::segments_t             hex7,
    output logic [maze_pkg::VGA_X_BITS-1:0] vga_x,
    output logic [maze_pkg::VGA_Y_BITS-1:0] vga_y,
    output maze_pkg::colour_t               vga_colour,
    output logic                            vga_write
);
    import maze_pkg::*;

    logic        load_start;
    logic        load_done;
    logic        draw_start;
    logic        draw_done;
    logic        update_start;
    logic        update_done;
    logic        store;
    grid_owner_t owner;
    pos_x_t      pos_x;
    pos_y_t      pos_y;
    angle_t      angle;

    grid_port_if load_port ();
    grid_port_if draw_port ();
    grid_port_if motion_port ();

    game_sequencer game_sequencer_inst (
        .clock        (clock),
        .reset        (reset),
        .load_done    (load_done),
        .draw_done    (draw_done),
        .update_done  (update_done),
        .load_start   (load_start),
        .draw_start   (draw_start),
        .update_start (update_start),
        .store        (store),
        .owner        (owner)
    );

    grid_store grid_store_inst (
        .clock       (clock),
        .owner       (owner),
        .load_port   (load_port),
        .draw_port   (draw_port),
        .motion_port (motion_port)
    );

    level_loader level_loader_inst (
        .clock (clock),
        .reset (reset),
        .start (load_start),
        .done  (load_done),
        .grid  (load_port)
    );

    map_renderer map_renderer_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (draw_start),
        .done       (draw_done),
        .grid       (draw_port),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_write  (vga_write)
    );

    player_motion player_motion_inst (
        .clock         (clock),
        .reset         (reset),
        .start         (update_start),
        .store         (store),
        .turn_right    (sw[1]),
        .turn_left     (sw[2]),
        .move_forward  (sw[3]),
        .move_backward (sw[4]),
        .done          (update_done),
        .grid          (motion_port),
        .pos_x         (pos_x),
        .pos_y         (pos_y),
        .angle         (angle)
    );

    hex_readout hex_readout_inst (
        .pos_x (pos_x),
        .pos_y (pos_y),
        .angle (angle),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex4  (hex4),
        .hex5  (hex5),
        .hex6  (hex6),
        .hex7  (hex7)
    );

endmodule

// File: hw/player_motion.sv
`timescale 1ns/1ps

module player_motion (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  logic             store,
    input  logic             turn_right,
    input  logic             turn_left,
    input  logic             move_forward,
    input  logic             move_backward,
    output logic             done,
    grid_port_if.client      grid,
    output maze_pkg::pos_x_t pos_x,
    output maze_pkg::pos_y_t pos_y,
    output maze_pkg::angle_t angle
);
    import maze_pkg::*;

    pos_x_t      next_x;
    pos_y_t      next_y;
    angle_t      next_angle;
    pos_x_t      step_x;
    pos_y_t      step_y;
    angle_t      turned;
    logic [1:0]  heading;
    logic        check;

    // Right wins over left
    always_comb begin
        turned = angle;
        if (turn_right)
            turned = angle + ANGLE_STEP;
        else if (turn_left)
            turned = angle - ANGLE_STEP;
    end

    // Backward flips the quadrant by two
    assign heading = move_forward ? angle[7:6] : (angle[7:6] ^ 2'b10);

    always_comb begin
        step_x = pos_x;
        step_y = pos_y;
        if (move_forward || move_backward) begin
            case (heading)
                2'd0:    step_x = pos_x + pos_x_t'(MOVE_STEP);
                2'd1:    step_y = pos_y + pos_y_t'(MOVE_STEP);
                2'd2:    step_x = pos_x - pos_x_t'(MOVE_STEP);
                default: step_y = pos_y - pos_y_t'(MOVE_STEP);
            endcase
        end
    end

    // Target cell of the candidate move
    assign grid.x     = next_x[FRAC_BITS +: GRID_X_BITS];
    assign grid.y     = next_y[FRAC_BITS +: GRID_Y_BITS];
    assign grid.write = 1'b0;
    assign grid.wdata = CELL_FLOOR;

    always_ff @(posedge clock) begin
        if (start) begin
            next_x     <= step_x;
            next_y     <= step_y;
            next_angle <= turned;
        end else if (done && grid.rdata == CELL_WALL) begin
            // Blocked, keep the turn only
            next_x <= pos_x;
            next_y <= pos_y;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pos_x <= START_X;
            pos_y <= START_Y;
            angle <= '0;
            check <= 1'b0;
            done  <= 1'b0;
        end else begin
            check <= start;
            done  <= check;
            if (store) begin
                pos_x <= next_x;
                pos_y <= next_y;
                angle <= next_angle;
            end
        end
    end

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);
    localparam realtime HALF_PERIOD  = 2ns;
    localparam int      RESET_CYCLES = 16;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// File: testbench/maze_assert.sv
`timescale 1ns/1ps

module maze_assert (
    input logic                            clock,
    input logic                            reset,
    input logic [17:0]                     sw,
    input maze_pkg::segments_t             hex0,
    input maze_pkg::segments_t             hex1,
    input maze_pkg::segments_t             hex4,
    input maze_pkg::segments_t             hex5,
    input maze_pkg::segments_t             hex6,
    input maze_pkg::segments_t             hex7,
    input logic [maze_pkg::VGA_X_BITS-1:0] vga_x,
    input logic [maze_pkg::VGA_Y_BITS-1:0] vga_y,
    input maze_pkg::colour_t               vga_colour,
    input logic                            vga_write,
    input logic                            update_start,
    input logic                            store,
    input maze_pkg::pos_x_t                pos_x,
    input maze_pkg::pos_y_t                pos_y,
    input maze_pkg::angle_t                angle
);
    import maze_pkg::*;

    // Active low with segment a in bit 0
    localparam segments_t DIGITS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    // Start position reads 18 18 and angle reads 00
    localparam logic [41:0] RESET_HEX = {DIGITS[1], DIGITS[8], DIGITS[1], DIGITS[8],
                                         DIGITS[0], DIGITS[0]};

    logic                  failed = 1'b0;
    logic [LIMIT_BITS-1:0] limit_model;
    logic                  window_q;
    logic [3:0]            keys_q;
    logic                  check_q;
    logic                  back_q;
    logic [1:0]            dir;
    logic                  blocked;
    logic [41:0]           shown_hex;
    logic [41:0]           want_hex;
    colour_t               want_colour;
    angle_t                exp_angle;
    angle_t                exp_angle_q;
    angle_t                prev_angle;
    angle_t                want_angle;
    pos_x_t                tgt_x;
    pos_y_t                tgt_y;
    pos_x_t                exp_x_q;
    pos_y_t                exp_y_q;
    pos_x_t                prev_x;
    pos_y_t                prev_y;
    pos_x_t                want_x;
    pos_y_t                want_y;

    function automatic logic is_wall(input int unsigned x, input int unsigned y);
        logic pillar;
        pillar = (x % PILLAR_SPACING == PILLAR_OFFSET) && (y % PILLAR_SPACING == PILLAR_OFFSET);
        return (x == 0) || (x == 63) || (y == 0) || (y == 31) || pillar;
    endfunction

    assign shown_hex = {hex7, hex6, hex5, hex4, hex1, hex0};
    assign want_hex = {DIGITS[pos_x[11:8]], DIGITS[pos_x[7:4]], DIGITS[pos_y[11:8]],
                       DIGITS[pos_y[7:4]], DIGITS[angle[7:4]], DIGITS[angle[3:0]]};
    assign want_colour = is_wall(vga_x, vga_y) ? WALL_COLOUR : FLOOR_COLOUR;

    // Backward walks the opposite quadrant
    assign dir = keys_q[2] ? angle[7:6] : angle[7:6] + 2'd2;
    assign blocked = is_wall(tgt_x[FRAC_BITS +: GRID_X_BITS], tgt_y[FRAC_BITS +: GRID_Y_BITS]);
    assign want_angle = check_q ? exp_angle_q : prev_angle;
    assign want_x = check_q ? exp_x_q : prev_x;
    assign want_y = check_q ? exp_y_q : prev_y;

    always_comb begin
        exp_angle = angle;
        if (keys_q[0])
            exp_angle = angle + ANGLE_STEP;
        else if (keys_q[1])
            exp_angle = angle - ANGLE_STEP;
        tgt_x = pos_x;
        tgt_y = pos_y;
        if (keys_q[2] || keys_q[3]) begin
            case (dir)
                2'd0:    tgt_x = pos_x + pos_x_t'(MOVE_STEP);
                2'd1:    tgt_y = pos_y + pos_y_t'(MOVE_STEP);
                2'd2:    tgt_x = pos_x - pos_x_t'(MOVE_STEP);
                default: tgt_y = pos_y - pos_y_t'(MOVE_STEP);
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset || limit_model == '0)
            limit_model <= FRAME_PERIOD;
        else
            limit_model <= limit_model - 1'b1;
        window_q   <= !reset && (limit_model < DRAW_WINDOW);
        prev_x     <= pos_x;
        prev_y     <= pos_y;
        prev_angle <= angle;
        check_q    <= store && !reset;
        back_q     <= store && !reset && keys_q[3] && !keys_q[2] && (angle == '0);
        if (update_start)
            keys_q <= sw[4:1];
        if (store) begin
            exp_angle_q <= exp_angle;
            exp_x_q     <= blocked ? pos_x : tgt_x;
            exp_y_q     <= blocked ? pos_y : tgt_y;
        end
    end

    reset_state: assert property (@(posedge clock) $fell(reset) |->
        !vga_write && shown_hex == RESET_HEX)
        else begin
            failed = 1'b1;
            $error("** Error reset_state: expected hex %h write 0, actual hex %h write %0b",
                   RESET_HEX, $sampled(shown_hex), $sampled(vga_write));
        end

    hex_digits: assert property (@(posedge clock) disable iff (reset) shown_hex == want_hex)
        else begin
            failed = 1'b1;
            $error("** Error hex_digits: expected %h, actual %h",
                   $sampled(want_hex), $sampled(shown_hex));
        end

    draw_window: assert property (@(posedge clock) disable iff (reset)
        vga_write |-> window_q && vga_x < 64 && vga_y < 32)
        else begin
            failed = 1'b1;
            $error("VGA write outside the draw window or off the grid at x %0d y %0d",
                   $sampled(vga_x), $sampled(vga_y));
        end

    pixel_colour: assert property (@(posedge clock) disable iff (reset)
        vga_write |-> vga_colour == want_colour)
        else begin
            failed = 1'b1;
            $error("** Error pixel_colour: expected %h, actual %h",
                   $sampled(want_colour), $sampled(vga_colour));
        end

    angle_step: assert property (@(posedge clock) disable iff (reset)
        angle != prev_angle |-> angle_t'(angle - prev_angle) == ANGLE_STEP ||
                                angle_t'(prev_angle - angle) == ANGLE_STEP)
        else begin
            failed = 1'b1;
            $error("Angle jumped from %0d to %0d", $sampled(prev_angle), $sampled(angle));
        end

    turning: assert property (@(posedge clock) disable iff (reset) angle == want_angle)
        else begin
            failed = 1'b1;
            $error("** Error turning: expected %0d, actual %0d",
                   $sampled(want_angle), $sampled(angle));
        end

    moving: assert property (@(posedge clock) disable iff (reset)
        pos_x == want_x && pos_y == want_y)
        else begin
            failed = 1'b1;
            $error("** Error moving: expected %h,%h, actual %h,%h", $sampled(want_x),
                   $sampled(want_y), $sampled(pos_x), $sampled(pos_y));
        end

    // The west wall is cell 0 so x stays at cell 1 or above
    backward: assert property (@(posedge clock) disable iff (reset)
        back_q |-> (pos_x == prev_x - pos_x_t'(MOVE_STEP) || pos_x == prev_x) &&
                   pos_y == prev_y && pos_x >= pos_x_t'(1 << FRAC_BITS))
        else begin
            failed = 1'b1;
            $error("Backward move at angle 0 went from x %h to %h",
                   $sampled(prev_x), $sampled(pos_x));
        end

endmodule

bind maze_top maze_assert maze_assert_inst (
    .clock        (clock),
    .reset        (reset),
    .sw           (sw),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex4         (hex4),
    .hex5         (hex5),
    .hex6         (hex6),
    .hex7         (hex7),
    .vga_x        (vga_x),
    .vga_y        (vga_y),
    .vga_colour   (vga_colour),
    .vga_write    (vga_write),
    .update_start (update_start),
    .store        (store),
    .pos_x        (pos_x),
    .pos_y        (pos_y),
    .angle        (angle)
);

// File: testbench/tb_maze_top.sv
`timescale 1ns/1ps

module tb_maze_top;
    import maze_pkg::*;

    // 42 updates of about one frame each, plus the load, with margin
    localparam int TIMEOUT_CYCLES = 300000;

    logic                  clock;
    logic                  reset;
    logic [17:0]           sw;
    segments_t             hex0;
    segments_t             hex1;
    segments_t             hex4;
    segments_t             hex5;
    segments_t             hex6;
    segments_t             hex7;
    logic [VGA_X_BITS-1:0] vga_x;
    logic [VGA_Y_BITS-1:0] vga_y;
    colour_t               vga_colour;
    logic                  vga_write;
    int                    cycles = 0;

    clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    maze_top maze_top_inst (
        .clock      (clock),
        .reset      (reset),
        .sw         (sw),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex4       (hex4),
        .hex5       (hex5),
        .hex6       (hex6),
        .hex7       (hex7),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_write  (vga_write)
    );

    // Returns 1 ns after the edge that raised store
    task automatic wait_store();
        do begin
            @(posedge clock);
            #1;
        end while (!maze_top_inst.store);
    endtask

    // keys are back, forward, left, right on sw[4:1]
    task automatic hold_keys(input logic [3:0] keys, input int updates);
        sw = {13'd0, keys, 1'b0};
        repeat (updates)
            wait_store();
    endtask

    task automatic random_keys(input int updates);
        repeat (updates) begin
            sw = 18'($urandom());
            wait_store();
        end
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        wait (maze_top_inst.maze_assert_inst.failed);
        $display("TESTS FAILED");
        $fatal(1, "A DUT check failed");
    end

    initial begin
        sw = '0;
        void'($urandom(53));
        wait (reset === 1'b0);
        @(posedge clock);
        #1;
        hold_keys(4'b0000, 2);
        hold_keys(4'b0001, 4);
        hold_keys(4'b0010, 4);
        // Pinned at cell 1 after four steps
        hold_keys(4'b1000, 6);
        hold_keys(4'b0100, 6);
        random_keys(20);
        sw = '0;
        repeat (4) @(posedge clock);
        #1;
        if (maze_top_inst.maze_assert_inst.failed) begin
            $display("TESTS FAILED");
            $fatal(1, "A DUT check failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
